// File: design/flash_config.svh
//------------------------------------------------------------
// build-time constants of the flash read window
// include where ports or address math need sizing
//------------------------------------------------------------
`ifndef FLASH_CONFIG_SVH
`define FLASH_CONFIG_SVH

// word address seen by the ports
`define FLASH_WORD_AW 18

// flash byte address sent after the command
`define FLASH_BYTE_AW 24

// window starts 1 MiB into the flash
`define FLASH_BASE_ADDR 24'h100000

// plain serial read, no dummy cycles
`define FLASH_READ_CMD 8'h03

// instruction port and data port
`define FLASH_NPORTS 2

`endif

// File: design/flash_pkg.sv
//------------------------------------------------------------
// payload and pin types shared by the flash read window
// referenced as flash_pkg::name throughout
//------------------------------------------------------------
`default_nettype none

`include "flash_config.svh"

package flash_pkg;

   // request payload, one flash word
   typedef struct packed {
      logic [`FLASH_WORD_AW-1:0] word_address; // offset from window base
   } flash_req_t;

   // response payload, little-endian word
   typedef struct packed {
      logic [31:0] rdata; // lowest flash byte in 7:0
   } flash_rsp_t;

   // outgoing flash pins, miso kept apart as an input
   typedef struct packed {
      logic sck;  // serial clock, idles low
      logic cs_n; // chip select, active low
      logic mosi; // command/address out
   } spi_pins_t;

endpackage

`default_nettype wire

// File: design/spi_flash_reader.sv
//------------------------------------------------------------
// serial engine for one 32-bit read from SPI NOR flash
// sends 0x03 plus byte address and shifts in 4 bytes
// fixed 131 cycles from rd_req to rd_ack
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "flash_config.svh"

module spi_flash_reader (
   input  wire                     clk,
   input  wire                     rstrb,
   input  logic                    rd_req,
   input  flash_pkg::flash_req_t   rd_addr,
   output logic                    rd_ack,
   output flash_pkg::flash_rsp_t   rd_data,
   output flash_pkg::spi_pins_t    spi,
   input  logic                    miso
);

   typedef enum logic [1:0] {R_IDLE, R_XFER, R_TAIL, R_ACK} rstate_t;

   rstate_t                  state_q;
   logic [5:0]               snd_cnt;   // command/address bits left
   logic [5:0]               rcv_cnt;   // data bits left
   logic [1:0]               tail_cnt;  // cs_n hold after last sck
   logic [31:0]              cmd_q;     // shifts out msb first
   logic [31:0]              rcv_q;     // shifts in msb first
   logic                     sck_q;
   logic                     cs_n_q;
   logic                     mosi_w;
   logic [`FLASH_BYTE_AW-1:0] byte_addr;

   // word index -> byte address inside the window
   assign byte_addr = `FLASH_BASE_ADDR +
                      {{(`FLASH_BYTE_AW-`FLASH_WORD_AW-2){1'b0}}, rd_addr.word_address, 2'b00};

   assign mosi_w = (snd_cnt != 6'd0) && cmd_q[31]; // low once command is out
   assign spi    = '{sck: sck_q, cs_n: cs_n_q, mosi: mosi_w};

   // first byte received sits in 31:24 and moves to 7:0
   assign rd_data.rdata = {rcv_q[7:0], rcv_q[15:8], rcv_q[23:16], rcv_q[31:24]};

   always_ff @(posedge clk) begin
      if (rstrb) begin
         state_q  <= R_IDLE;
         snd_cnt  <= 6'd0;
         rcv_cnt  <= 6'd0;
         tail_cnt <= 2'd0;
         sck_q    <= 1'b0;
         cs_n_q   <= 1'b1;
         rd_ack   <= 1'b0;
      end else begin
         case (state_q)
            R_IDLE: begin
               if (rd_req) begin
                  cs_n_q  <= 1'b0;            // select on the cycle after req
                  snd_cnt <= 6'd32;
                  state_q <= R_XFER;
               end
            end
            R_XFER: begin
               sck_q <= ~sck_q;               // one sck half period per clk
               if (!sck_q) begin
                  // flash data is stable at the rising sck
                  if (rcv_cnt != 6'd0)
                     rcv_cnt <= rcv_cnt - 6'd1;
               end else if (snd_cnt != 6'd0) begin
                  // next mosi bit on the falling sck
                  snd_cnt <= snd_cnt - 6'd1;
                  if (snd_cnt == 6'd1)
                     rcv_cnt <= 6'd32;        // flash starts driving data now
               end else if (rcv_cnt == 6'd0) begin
                  tail_cnt <= 2'd2;           // sck back low after the 64th fall
                  state_q  <= R_TAIL;
               end
            end
            R_TAIL: begin
               if (tail_cnt == 2'd0) begin
                  cs_n_q  <= 1'b1;            // deselect and answer together
                  rd_ack  <= 1'b1;
                  state_q <= R_ACK;
               end else begin
                  tail_cnt <= tail_cnt - 2'd1;
               end
            end
            R_ACK: begin
               if (!rd_req) begin
                  rd_ack  <= 1'b0;
                  state_q <= R_IDLE;
               end
            end
            default: state_q <= R_IDLE;
         endcase
      end
   end

   // command out and data in
   always_ff @(posedge clk) begin
      if (state_q == R_IDLE && rd_req)
         cmd_q <= {`FLASH_READ_CMD, byte_addr};
      else if (state_q == R_XFER && sck_q && snd_cnt != 6'd0)
         cmd_q <= {cmd_q[30:0], 1'b0};
      if (state_q == R_XFER && !sck_q && rcv_cnt != 6'd0)
         rcv_q <= {rcv_q[30:0], miso};
   end

   // a transfer in flight keeps the flash selected
   a_cs_held: assert property (@(posedge clk) disable iff (rstrb)
      (snd_cnt != 6'd0 || rcv_cnt != 6'd0) |-> !spi.cs_n);

   // the word is only handed back with the bus released
   a_ack_deselected: assert property (@(posedge clk) disable iff (rstrb)
      $rose(rd_ack) |-> spi.cs_n);

endmodule

`default_nettype wire

// File: design/flash_arbiter.sv
//------------------------------------------------------------
// round-robin arbiter in front of the single flash reader
// holds a grant for one full four-phase cycle downstream
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "flash_config.svh"

module flash_arbiter #(
   parameter type req_t = flash_pkg::flash_req_t,
   parameter type rsp_t = flash_pkg::flash_rsp_t
) (
   input  wire   clk,
   input  wire   rstrb,
   input  logic  mem_req  [`FLASH_NPORTS],
   input  req_t  mem_addr [`FLASH_NPORTS],
   output logic  mem_ack  [`FLASH_NPORTS],
   output rsp_t  mem_data [`FLASH_NPORTS],
   output logic  rd_req,
   output req_t  rd_addr,
   input  logic  rd_ack,
   input  rsp_t  rd_data
);

   localparam int N  = `FLASH_NPORTS;
   localparam int PW = (N > 1) ? $clog2(N) : 1;

   logic [PW-1:0] rr_ptr;    // port with first claim
   logic [PW-1:0] grant_q;   // owner of the reader
   logic [PW-1:0] pick;      // next winner
   logic          busy_q;
   logic          any_pend;
   logic [N-1:0]  ack_vec;   // packed copy for the check below
   req_t          addr_q;
   int            scan_idx;

   assign rd_addr = addr_q;

   // scan from the pointer, first pending port wins
   always_comb begin
      pick     = rr_ptr;
      any_pend = 1'b0;
      scan_idx = 0;
      for (int i = 0; i < N; i++) begin
         scan_idx = int'(rr_ptr) + i;
         if (scan_idx >= N)
            scan_idx = scan_idx - N;
         if (!any_pend && mem_req[scan_idx]) begin
            any_pend = 1'b1;
            pick     = PW'(scan_idx);
         end
      end
   end

   // ack and data go to the owner only, no added delay
   always_comb begin
      for (int i = 0; i < N; i++) begin
         ack_vec[i]  = busy_q && (grant_q == PW'(i)) && rd_ack;
         mem_ack[i]  = ack_vec[i];
         mem_data[i] = (busy_q && grant_q == PW'(i)) ? rd_data : '0;
      end
   end

   always_ff @(posedge clk) begin
      if (rstrb) begin
         busy_q  <= 1'b0;
         rd_req  <= 1'b0;
         grant_q <= '0;
         rr_ptr  <= '0;                      // port 0 first
      end else if (!busy_q) begin
         if (any_pend) begin
            busy_q  <= 1'b1;
            grant_q <= pick;
            rd_req  <= 1'b1;                 // one cycle on the way in
         end
      end else begin
         if (rd_req && !mem_req[grant_q])
            rd_req <= 1'b0;                  // owner has seen its ack
         if (!rd_req && !rd_ack) begin
            busy_q <= 1'b0;                  // handshake fully closed
            rr_ptr <= (int'(grant_q) == N - 1) ? '0 : grant_q + 1'b1;
         end
      end
   end

   // payload held for the reader
   always_ff @(posedge clk) begin
      if (!busy_q && any_pend)
         addr_q <= mem_addr[pick];
   end

   a_one_ack: assert property (@(posedge clk) disable iff (rstrb) $onehot0(ack_vec));

endmodule

`default_nettype wire

// File: design/flash_word_cache.sv
//------------------------------------------------------------
// one-word cache per port, answers repeat reads locally
// misses go downstream, entry cleared only by reset
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module flash_word_cache (
   input  wire                    clk,
   input  wire                    rstrb,
   input  logic                   port_req,
   input  flash_pkg::flash_req_t  port_addr,
   output logic                   port_ack,
   output flash_pkg::flash_rsp_t  port_data,
   output logic                   mem_req,
   output flash_pkg::flash_req_t  mem_addr,
   input  logic                   mem_ack,
   input  flash_pkg::flash_rsp_t  mem_data
);

   typedef enum logic [1:0] {C_IDLE, C_MISS, C_HIT, C_DONE} cstate_t;

   cstate_t               state_q;
   logic                  valid_q;
   logic                  hit;
   flash_pkg::flash_req_t tag_q;   // address of the held word
   flash_pkg::flash_rsp_t data_q;  // the held word

   assign hit       = valid_q && (tag_q == port_addr);
   assign mem_addr  = port_addr;   // stable while port_req is high
   assign port_data = data_q;      // valid whenever port_ack is high

   always_ff @(posedge clk) begin
      if (rstrb) begin
         state_q  <= C_IDLE;
         valid_q  <= 1'b0;
         port_ack <= 1'b0;
         mem_req  <= 1'b0;
      end else begin
         case (state_q)
            C_IDLE: begin
               if (port_req) begin
                  if (hit) begin
                     port_ack <= 1'b1;       // ack on the next cycle
                     state_q  <= C_HIT;
                  end else if (!mem_ack) begin
                     mem_req <= 1'b1;        // previous downstream ack gone
                     state_q <= C_MISS;
                  end
               end
            end
            C_MISS: begin
               if (mem_ack) begin
                  mem_req  <= 1'b0;
                  valid_q  <= 1'b1;
                  port_ack <= 1'b1;
                  state_q  <= C_DONE;
               end
            end
            C_HIT, C_DONE: begin
               if (!port_req) begin
                  port_ack <= 1'b0;
                  state_q  <= C_IDLE;
               end
            end
            default: state_q <= C_IDLE;
         endcase
      end
   end

   // fill on the downstream ack
   always_ff @(posedge clk) begin
      if (state_q == C_MISS && mem_ack) begin
         tag_q  <= port_addr;
         data_q <= mem_data;
      end
   end

   // a hit leaves the arbiter and reader alone
   a_hit_local: assert property (@(posedge clk) disable iff (rstrb)
      (state_q == C_HIT) |-> (!mem_req && !mem_ack));

endmodule

`default_nettype wire

// File: design/flash_read_top.sv
//------------------------------------------------------------
// two-port read window onto SPI flash
// per-port caches feed a round-robin arbiter and one reader
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "flash_config.svh"

module flash_read_top (
   input  wire                    clk,
   input  wire                    rstrb,
   input  logic                   port_req  [`FLASH_NPORTS],
   input  flash_pkg::flash_req_t  port_addr [`FLASH_NPORTS],
   output logic                   port_ack  [`FLASH_NPORTS],
   output flash_pkg::flash_rsp_t  port_data [`FLASH_NPORTS],
   output flash_pkg::spi_pins_t   spi,
   input  logic                   miso
);

   // cache -> arbiter
   logic                  mem_req  [`FLASH_NPORTS];
   flash_pkg::flash_req_t mem_addr [`FLASH_NPORTS];
   logic                  mem_ack  [`FLASH_NPORTS];
   flash_pkg::flash_rsp_t mem_data [`FLASH_NPORTS];

   // arbiter -> reader
   logic                  rd_req;
   flash_pkg::flash_req_t rd_addr;
   logic                  rd_ack;
   flash_pkg::flash_rsp_t rd_data;

   for (genvar k = 0; k < `FLASH_NPORTS; k++) begin : g_cache
      flash_word_cache cache_i (
         .clk       (clk),
         .rstrb     (rstrb),
         .port_req  (port_req[k]),
         .port_addr (port_addr[k]),
         .port_ack  (port_ack[k]),
         .port_data (port_data[k]),
         .mem_req   (mem_req[k]),
         .mem_addr  (mem_addr[k]),
         .mem_ack   (mem_ack[k]),
         .mem_data  (mem_data[k])
      );
   end

   flash_arbiter #(
      .req_t (flash_pkg::flash_req_t),
      .rsp_t (flash_pkg::flash_rsp_t)
   ) arb_i (
      .clk      (clk),
      .rstrb    (rstrb),
      .mem_req  (mem_req),
      .mem_addr (mem_addr),
      .mem_ack  (mem_ack),
      .mem_data (mem_data),
      .rd_req   (rd_req),
      .rd_addr  (rd_addr),
      .rd_ack   (rd_ack),
      .rd_data  (rd_data)
   );

   spi_flash_reader reader_i (
      .clk     (clk),
      .rstrb   (rstrb),
      .rd_req  (rd_req),
      .rd_addr (rd_addr),
      .rd_ack  (rd_ack),
      .rd_data (rd_data),
      .spi     (spi),
      .miso    (miso)
   );

endmodule

`default_nettype wire

// File: test/spi_flash_model.sv
//------------------------------------------------------------
// behavioral SPI NOR flash for the testbench
// takes a read command and address, returns generated bytes
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "flash_config.svh"

module spi_flash_model (
   input  flash_pkg::spi_pins_t spi,
   output logic                 miso,
   output logic                 cmd_err   // sticky, wrong command byte seen
);

   logic [31:0]                cmd_sr;    // command and address, msb first
   logic [`FLASH_BYTE_AW-1:0]  addr_q;
   int                         bit_cnt;   // mosi bits taken so far
   int                         out_cnt;   // miso bits given so far

   // contents of the flash at byte address b
   function automatic logic [7:0] flash_byte(input logic [23:0] b);
      logic [23:0] t;
      t = b * 24'd7 + 24'd3;
      return t[7:0] ^ b[15:8];
   endfunction

   initial begin
      miso    = 1'b0;
      cmd_err = 1'b0;
      bit_cnt = 0;
      out_cnt = 0;
   end

   // new transaction on every select
   always @(negedge spi.cs_n) begin
      bit_cnt = 0;
      out_cnt = 0;
   end

   // mosi is stable around the rising sck
   always @(posedge spi.sck) begin
      if (!spi.cs_n && bit_cnt < 32) begin
         cmd_sr  = {cmd_sr[30:0], spi.mosi};
         bit_cnt = bit_cnt + 1;
         if (bit_cnt == 32) begin
            addr_q = cmd_sr[23:0];
            if (cmd_sr[31:24] !== `FLASH_READ_CMD)
               cmd_err = 1'b1;
         end
      end
   end

   // data bits change on the falling sck, bytes in address order
   always @(negedge spi.sck) begin
      logic [7:0] cur;
      if (!spi.cs_n && bit_cnt == 32 && out_cnt < 32) begin
         cur     = flash_byte(addr_q + 24'(out_cnt / 8));
         miso    <= cur[7 - (out_cnt % 8)];   // msb first
         out_cnt = out_cnt + 1;
      end
   end

endmodule

`default_nettype wire

// File: test/tb_flash_read.sv
//------------------------------------------------------------
// testbench for the two-port flash read window
// runs both ports against a flash model and checks every word
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "flash_config.svh"

module tb_flash_read;

   localparam int RR_ROUNDS = 8;
   localparam int N_RAND    = 100;   // per port and 200 in total
   localparam int READS     = 1 + RR_ROUNDS + 6 + N_RAND;   // most reads of one port
   localparam longint WATCHDOG_NS = longint'(READS) * 2 * 140 * 4 * 2;

   logic                  clk = 1'b0;
   logic                  rstrb;
   logic                  port_req  [`FLASH_NPORTS];
   flash_pkg::flash_req_t port_addr [`FLASH_NPORTS];
   logic                  port_ack  [`FLASH_NPORTS];
   flash_pkg::flash_rsp_t port_data [`FLASH_NPORTS];
   flash_pkg::spi_pins_t  spi_w;
   logic                  miso;
   logic                  cmd_err;

   int                    done_cnt  [`FLASH_NPORTS];   // rising acks seen
   int                    rr_base   [`FLASH_NPORTS];
   logic                  rr_on;                       // fairness watch on
   logic                  ack_prev  [`FLASH_NPORTS];
   logic                  req_prev  [`FLASH_NPORTS];
   flash_pkg::flash_req_t addr_prev [`FLASH_NPORTS];
   int                    issued;
   int                    cs_falls;

   always #2 clk = ~clk;

   flash_read_top dut_i (
      .clk       (clk),
      .rstrb     (rstrb),
      .port_req  (port_req),
      .port_addr (port_addr),
      .port_ack  (port_ack),
      .port_data (port_data),
      .spi       (spi_w),
      .miso      (miso)
   );

   spi_flash_model flash_i (.spi(spi_w), .miso(miso), .cmd_err(cmd_err));

   task automatic stop_with_error(input string why);
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
         stop_with_error($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
   endtask

   // reference contents of the flash
   function automatic logic [7:0] flash_byte(input logic [23:0] b);
      logic [23:0] t;
      t = b * 24'd7 + 24'd3;
      return t[7:0] ^ b[15:8];
   endfunction

   // four bytes from the window with the lowest address in 7:0
   function automatic logic [31:0] expected_word(input logic [`FLASH_WORD_AW-1:0] wa);
      logic [23:0] ba;
      logic [31:0] w;
      ba = `FLASH_BASE_ADDR + {4'b0, wa, 2'b00};
      for (int i = 0; i < 4; i++)
         w[8*i +: 8] = flash_byte(ba + 24'(i));
      return w;
   endfunction

   // one full four-phase read with inputs changed on the falling clk
   task automatic do_read(input int k, input logic [`FLASH_WORD_AW-1:0] a,
                          input int gap, input int hold);
      repeat (gap) @(negedge clk);
      @(negedge clk);
      port_addr[k].word_address = a;
      port_req[k] = 1'b1;
      while (!port_ack[k]) @(negedge clk);
      repeat (hold) @(negedge clk);
      port_req[k] = 1'b0;
      while (port_ack[k]) @(negedge clk);
      issued++;
   endtask

   task automatic back_to_back(input int k, input int n, input logic [`FLASH_WORD_AW-1:0] base);
      for (int i = 0; i < n; i++)
         do_read(k, base + i, 0, 0);   // a new address each time so every read misses
   endtask

   task automatic random_reads(input int k, input int n);
      logic [31:0]               r;
      logic [`FLASH_WORD_AW-1:0] a;
      for (int i = 0; i < n; i++) begin
         r = $urandom;
         a = ($urandom_range(0, 1) == 0) ? r[2:0] : r[`FLASH_WORD_AW-1:0];   // small set hits often
         do_read(k, a, $urandom_range(0, 6), $urandom_range(0, 4));
      end
   endtask

   // ack, req and address are sampled at each posedge before the DUT updates
   always @(posedge clk) begin
      int diff;
      for (int k = 0; k < `FLASH_NPORTS; k++) begin
         if (!rstrb && port_ack[k] && !ack_prev[k]) begin
            if (!req_prev[k])
               stop_with_error("ack rose without req");
            check_value($sformatf("port_data[%0d]", k), port_data[k].rdata,
                        expected_word(addr_prev[k].word_address));
            done_cnt[k]++;
         end
         ack_prev[k]  = port_ack[k];
         req_prev[k]  = port_req[k];
         addr_prev[k] = port_addr[k];
      end
      diff = (done_cnt[0] - rr_base[0]) - (done_cnt[1] - rr_base[1]);
      if (rr_on && (diff > 1 || diff < -1))
         stop_with_error("round robin let one port run ahead");
   end

   always @(negedge spi_w.cs_n)
      if (rstrb === 1'b0)
         cs_falls++;

   always @(posedge cmd_err)
      stop_with_error("flash model saw unknown command");

   initial begin
      #(WATCHDOG_NS);
      stop_with_error("timeout: transactions did not finish");
   end

   initial begin
      int fall_base;
      void'($urandom(32'he4d4_bd02));
      rstrb    = 1'b1;
      rr_on    = 1'b0;
      issued   = 0;
      cs_falls = 0;
      for (int k = 0; k < `FLASH_NPORTS; k++) begin
         port_req[k]  = 1'b0;
         port_addr[k] = '0;
         done_cnt[k]  = 0;
         rr_base[k]   = 0;
         ack_prev[k]  = 1'b0;
         req_prev[k]  = 1'b0;
         addr_prev[k] = '0;
      end
      repeat (4) @(negedge clk);
      rstrb = 1'b0;

      // idle pins and quiet ports after reset
      repeat (3) begin
         @(negedge clk);
         check_value("spi.cs_n", spi_w.cs_n, 1'b1);
         check_value("spi.sck", spi_w.sck, 1'b0);
         check_value("spi.mosi", spi_w.mosi, 1'b0);
         check_value("port_ack[0]", port_ack[0], 1'b0);
         check_value("port_ack[1]", port_ack[1], 1'b0);
      end

      do_read(0, 18'h00005, 0, 0);
      do_read(1, 18'h3fffe, 0, 0);

      // both ports hammer the flash together
      rr_base[0] = done_cnt[0];
      rr_base[1] = done_cnt[1];
      rr_on      = 1'b1;
      fork
         back_to_back(0, RR_ROUNDS, 18'h00100);
         back_to_back(1, RR_ROUNDS, 18'h20100);
      join
      rr_on = 1'b0;
      check_value("rr reads port 0", done_cnt[0] - rr_base[0], RR_ROUNDS);
      check_value("rr reads port 1", done_cnt[1] - rr_base[1], RR_ROUNDS);

      // repeats hit the cache and leave the flash deselected
      do_read(0, 18'h00777, 0, 0);
      fall_base = cs_falls;
      repeat (4) do_read(0, 18'h00777, 1, 2);
      check_value("cs_n fall count", cs_falls, fall_base);
      do_read(0, 18'h00778, 0, 0);
      check_value("cs_n fall count", cs_falls, fall_base + 1);

      fork
         random_reads(0, N_RAND);
         random_reads(1, N_RAND);
      join

      repeat (2) @(negedge clk);
      check_value("port_ack[0]", port_ack[0], 1'b0);
      check_value("port_ack[1]", port_ack[1], 1'b0);
      check_value("completions", done_cnt[0] + done_cnt[1], issued);
      $display("All tests passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
+incdir+design
design/flash_pkg.sv
design/spi_flash_reader.sv
design/flash_arbiter.sv
design/flash_word_cache.sv
design/flash_read_top.sv
test/spi_flash_model.sv
test/tb_flash_read.sv
